// ==== bench/tb_apb_gpio.sv ====
module tb_apb_gpio;

    timeunit 1ns;
    timeprecision 100ps;

    import gpio_pkg::*;

    logic                          HCLK;
    logic                          HRESETn;
    apb_addr_t                     PADDR;
    bus_word_t                     PWDATA;
    logic                          PWRITE;
    logic                          PSEL;
    logic                          PENABLE;
    bus_word_t                     PRDATA;
    logic                          PREADY;
    pad_vec_t                      gpio_in;
    pad_vec_t                      gpio_in_sync;
    pad_vec_t                      gpio_out;
    pad_vec_t                      gpio_dir;
    pad_cfg_t [PAD_COUNT-1:0]      gpio_padcfg;
    logic                          interrupt;

    logic [31:0] lfsr_state;
    int_mode_t   mode_of [PAD_COUNT]; // Interrupt type per pad
    pad_vec_t    en_model;
    pad_vec_t    inten_model;

    apb_gpio i_apb_gpio (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .PADDR        (PADDR),
        .PWDATA       (PWDATA),
        .PWRITE       (PWRITE),
        .PSEL         (PSEL),
        .PENABLE      (PENABLE),
        .PRDATA       (PRDATA),
        .PREADY       (PREADY),
        .gpio_in      (gpio_in),
        .gpio_in_sync (gpio_in_sync),
        .gpio_out     (gpio_out),
        .gpio_dir     (gpio_dir),
        .gpio_padcfg  (gpio_padcfg),
        .interrupt    (interrupt)
    );

    always #50 HCLK = ~HCLK; // 100 ns period

    initial
    begin
        repeat (2000) @(posedge HCLK); // Tests need about 150 cycles
        $display("Watchdog expired before the tests completed");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog timeout");
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb)
        begin
            s = s ^ 32'h8020_0003;
        end
        return s;
    endfunction

    function automatic bus_word_t rand_word();
        bus_word_t w;
        w = '0;
        for (int i = 0; i < 32; i++)
        begin
            w[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state); // One step per bit
        end
        return w;
    endfunction

    function automatic apb_addr_t addr_of(reg_index_t idx);
        return apb_addr_t'({idx, 2'b00});
    endfunction

    task automatic report_error(string msg);
        $display("** Error @ %0d ns: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "check failed");
    endtask

    task automatic check_word(string what, bus_word_t actual, bus_word_t expected);
        if (actual !== expected)
        begin
            report_error($sformatf("%s expected %h, got %h", what, expected, actual));
        end
    endtask

    task automatic check_pads(string what, pad_vec_t actual, pad_vec_t expected);
        if (actual !== expected)
        begin
            report_error($sformatf("%s expected %h, got %h", what, expected, actual));
        end
    endtask

    task automatic check_bit(string what, logic actual, logic expected);
        if (actual !== expected)
        begin
            report_error($sformatf("%s expected %b, got %b", what, expected, actual));
        end
    endtask

    // Setup then access phase; called and returns 10 ns after a rising edge
    task automatic apb_access(apb_addr_t addr, logic write, bus_word_t wdata,
                              output bus_word_t rdata);
        PADDR   = addr;
        PWDATA  = wdata;
        PWRITE  = write;
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        @(posedge HCLK);
        #10;
        PENABLE = 1'b1;
        #30;
        while (!PREADY) // Wait states, bounded by the watchdog
        begin
            @(posedge HCLK);
            #40;
        end
        rdata = PRDATA;
        @(posedge HCLK); // Access edge
        #10;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
    endtask

    task automatic apb_write(apb_addr_t addr, bus_word_t data);
        bus_word_t unused;
        apb_access(addr, 1'b1, data, unused);
    endtask

    task automatic apb_read(apb_addr_t addr, output bus_word_t data);
        apb_access(addr, 1'b0, '0, data);
    endtask

    task automatic reset_values_are_zero();
        bus_word_t got;
        check_bit("PREADY", PREADY, 1'b1);
        check_pads("gpio_dir after reset", gpio_dir, '0);
        check_pads("gpio_out after reset", gpio_out, '0);
        check_bit("interrupt after reset", interrupt, 1'b0);
        for (int i = 0; i <= 13; i++)
        begin
            apb_read(addr_of(reg_index_t'(i)), got);
            check_word($sformatf("reset value of index %0d", i), got, '0);
        end
    endtask

    task automatic write_readback(reg_index_t idx, bus_word_t data);
        bus_word_t got;
        apb_write(addr_of(idx), data);
        apb_read(addr_of(idx), got);
        check_word($sformatf("readback of index %0d", idx), got, data);
    endtask

    task automatic control_regs_read_back();
        bus_word_t dir_word;
        bus_word_t data;
        bus_word_t got;
        dir_word = rand_word();
        apb_write(addr_of(REG_PADDIR), dir_word);
        @(posedge HCLK);
        #10;
        check_pads("gpio_dir", gpio_dir, dir_word);
        write_readback(REG_GPIOEN, rand_word());
        write_readback(REG_INTEN, rand_word());
        write_readback(REG_INTTYPE_LO, rand_word());
        write_readback(REG_INTTYPE_HI, rand_word());
        for (int g = 0; g < 4; g++)
        begin
            data = rand_word();
            write_readback(reg_index_t'(REG_PADCFG_0 + g), data);
            check_word($sformatf("gpio_padcfg group %0d", g), gpio_padcfg[8*g +: 8], data);
        end
        apb_write(addr_of(reg_index_t'(20)), rand_word()); // Unmapped word
        apb_write(addr_of(REG_PADIN), rand_word());
        apb_read(addr_of(reg_index_t'(20)), got);
        check_word("unmapped index 20", got, '0);
        apb_read(addr_of(REG_PADIN), got);
        check_word("PADIN after write", got, '0);
        apb_read(addr_of(REG_PADDIR), got);
        check_word("PADDIR after ignored writes", got, dir_word);
        check_pads("gpio_out after ignored writes", gpio_out, '0);
    endtask

    task automatic output_set_and_clear();
        bus_word_t first;
        bus_word_t set_data;
        bus_word_t clr_data;
        bus_word_t got;
        pad_vec_t  expected;
        first    = rand_word();
        set_data = rand_word();
        clr_data = rand_word();
        expected = (first | set_data) & ~clr_data;
        apb_write(addr_of(REG_PADOUT), first);
        apb_write(addr_of(REG_PADOUTSET), set_data);
        apb_write(addr_of(REG_PADOUTCLR), clr_data);
        @(posedge HCLK);
        #10;
        check_pads("gpio_out", gpio_out, expected);
        apb_read(addr_of(REG_PADOUT), got);
        check_word("PADOUT", got, expected);
    endtask

    task automatic input_path_latency();
        pad_vec_t  pads;
        bus_word_t got;
        pads    = rand_word();
        gpio_in = pads;
        repeat (2) @(posedge HCLK);
        #10;
        check_pads("gpio_in_sync", gpio_in_sync, pads);
        apb_read(addr_of(REG_PADIN), got); // Access cycle follows the 3rd edge
        check_word("PADIN", got, pads);
    endtask

    function automatic logic pulse_expected(int pad, logic rising);
        logic match;
        if (rising)
        begin
            match = (mode_of[pad] == INT_RISE) || (mode_of[pad] == INT_BOTH);
        end
        else
        begin
            match = (mode_of[pad] == INT_FALL) || (mode_of[pad] == INT_BOTH);
        end
        return match & en_model[pad] & inten_model[pad];
    endfunction

    task automatic toggle_pad(int pad, logic level, inout pad_vec_t status_model);
        logic pulse;
        pulse = pulse_expected(pad, level);
        gpio_in[pad] = level;
        @(posedge HCLK);
        #40;
        check_bit($sformatf("interrupt before sync, pad %0d", pad), interrupt, 1'b0);
        @(posedge HCLK);
        #40;
        check_bit($sformatf("interrupt pulse, pad %0d", pad), interrupt, pulse);
        @(posedge HCLK);
        #40;
        check_bit($sformatf("interrupt after pulse, pad %0d", pad), interrupt, 1'b0);
        @(posedge HCLK);
        #10;
        if (pulse)
        begin
            status_model[pad] = 1'b1;
        end
    endtask

    task automatic interrupt_type_rules();
        int        irq_pads [5] = '{3, 7, 12, 18, 25};
        bus_word_t type_lo;
        bus_word_t type_hi;
        bus_word_t got;
        pad_vec_t  status_model;
        apb_write(addr_of(REG_INTEN), '0);
        gpio_in = '0;
        repeat (4) @(posedge HCLK);
        #10;
        apb_read(addr_of(REG_INTSTATUS), got); // Flush bits left by earlier tests
        for (int i = 0; i < PAD_COUNT; i++)
        begin
            mode_of[i] = INT_NONE;
        end
        mode_of[3]  = INT_FALL;
        mode_of[7]  = INT_RISE;
        mode_of[12] = INT_BOTH;
        mode_of[25] = INT_RISE; // Pad enable stays clear
        for (int i = 0; i < 16; i++)
        begin
            type_lo[2*i +: 2] = mode_of[i];
            type_hi[2*i +: 2] = mode_of[16 + i];
        end
        inten_model = '0;
        foreach (irq_pads[k])
        begin
            inten_model[irq_pads[k]] = 1'b1;
        end
        en_model     = inten_model;
        en_model[25] = 1'b0;
        apb_write(addr_of(REG_INTTYPE_LO), type_lo);
        apb_write(addr_of(REG_INTTYPE_HI), type_hi);
        apb_write(addr_of(REG_GPIOEN), en_model);
        apb_write(addr_of(REG_INTEN), inten_model);
        status_model = '0;
        foreach (irq_pads[k])
        begin
            toggle_pad(irq_pads[k], 1'b1, status_model);
            toggle_pad(irq_pads[k], 1'b0, status_model);
        end
        apb_read(addr_of(REG_INTSTATUS), got);
        check_word("INTSTATUS", got, status_model);
        apb_read(addr_of(REG_INTSTATUS), got);
        check_word("INTSTATUS after clear", got, '0);
    endtask

    initial
    begin
        HCLK       = 1'b0;
        HRESETn    = 1'b0;
        PADDR      = '0;
        PWDATA     = '0;
        PWRITE     = 1'b0;
        PSEL       = 1'b0;
        PENABLE    = 1'b0;
        gpio_in    = '0;
        lfsr_state = 32'ha829;
        repeat (3) @(posedge HCLK);
        #10;
        HRESETn = 1'b1;
        reset_values_are_zero();
        control_regs_read_back();
        output_set_and_clear();
        input_path_latency();
        interrupt_type_rules();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== list.f ====
source/gpio_pkg.sv
source/gpio_bus_port.sv
source/gpio_ctrl_regs.sv
source/gpio_input_sync.sv
source/gpio_irq.sv
source/apb_gpio.sv
bench/tb_apb_gpio.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=sim_apb_gpio

verilator --binary --timing -f list.f --top-module tb_apb_gpio \
    -Mdir "$BUILD_DIR" -o "$SIM_EXE"
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./$BUILD_DIR/$SIM_EXE"
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation ended with status $sim_status"
    exit 1
fi

echo "Simulation ended with status 0"
exit 0

// ==== source/apb_gpio.sv ====
module apb_gpio (
    input  logic                                         HCLK,
    input  logic                                         HRESETn,
    input  gpio_pkg::apb_addr_t                          PADDR,
    input  gpio_pkg::bus_word_t                          PWDATA,
    input  logic                                         PWRITE,
    input  logic                                         PSEL,
    input  logic                                         PENABLE,
    output gpio_pkg::bus_word_t                          PRDATA,
    output logic                                         PREADY,
    input  gpio_pkg::pad_vec_t                           gpio_in,
    output gpio_pkg::pad_vec_t                           gpio_in_sync,
    output gpio_pkg::pad_vec_t                           gpio_out,
    output gpio_pkg::pad_vec_t                           gpio_dir,
    output gpio_pkg::pad_cfg_t [gpio_pkg::PAD_COUNT-1:0] gpio_padcfg,
    output logic                                         interrupt
);

    import gpio_pkg::*;

    reg_write_t  wr;
    logic        status_read;
    pad_ctrl_t   ctrl;
    pad_vec_t    pad_in;
    pad_events_t events;
    pad_vec_t    status;

    gpio_bus_port i_bus_port (
        .PADDR       (PADDR),
        .PWDATA      (PWDATA),
        .PWRITE      (PWRITE),
        .PSEL        (PSEL),
        .PENABLE     (PENABLE),
        .ctrl        (ctrl),
        .pad_in      (pad_in),
        .status      (status),
        .wr          (wr),
        .status_read (status_read),
        .PRDATA      (PRDATA)
    );

    gpio_ctrl_regs i_ctrl_regs (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .wr      (wr),
        .ctrl    (ctrl)
    );

    gpio_input_sync i_input_sync (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .gpio_in  (gpio_in),
        .pad_sync (gpio_in_sync),
        .pad_in   (pad_in),
        .events   (events)
    );

    gpio_irq i_irq (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .events      (events),
        .ctrl        (ctrl),
        .status_read (status_read),
        .status      (status),
        .interrupt   (interrupt)
    );

    assign gpio_out    = ctrl.out;
    assign gpio_dir    = ctrl.dir;
    assign gpio_padcfg = ctrl.padcfg;

    assign PREADY = 1'b1; // Zero wait states

endmodule

// ==== source/gpio_bus_port.sv ====
module gpio_bus_port (
    input  gpio_pkg::apb_addr_t  PADDR,
    input  gpio_pkg::bus_word_t  PWDATA,
    input  logic                 PWRITE,
    input  logic                 PSEL,
    input  logic                 PENABLE,
    input  gpio_pkg::pad_ctrl_t  ctrl,
    input  gpio_pkg::pad_vec_t   pad_in,
    input  gpio_pkg::pad_vec_t   status,
    output gpio_pkg::reg_write_t wr,
    output logic                 status_read,
    output gpio_pkg::bus_word_t  PRDATA
);

    import gpio_pkg::*;

    reg_index_t index;
    logic       access;
    logic       read_access;
    bus_word_t  read_word;

    assign index       = PADDR[6:2];
    assign access      = PSEL & PENABLE; // Access phase of APB
    assign read_access = access & ~PWRITE;

    assign wr = '{valid: access & PWRITE, index: index, data: PWDATA};

    assign status_read = read_access && (index == REG_INTSTATUS); // Clear-on-read strobe

    always_comb
    begin
        read_word = '0;
        case (index)
            REG_PADDIR:
                read_word = ctrl.dir;
            REG_GPIOEN:
                read_word = ctrl.en;
            REG_PADIN:
                read_word = pad_in;
            REG_PADOUT:
                read_word = ctrl.out;
            REG_INTEN:
                read_word = ctrl.inten;
            REG_INTTYPE_LO:
            begin
                for (int i = 0; i < 16; i++)
                begin
                    read_word[2*i +: 2] = ctrl.inttype[i];
                end
            end
            REG_INTTYPE_HI:
            begin
                for (int i = 0; i < 16; i++)
                begin
                    read_word[2*i +: 2] = ctrl.inttype[16 + i];
                end
            end
            REG_INTSTATUS:
                read_word = status;
            REG_PADCFG_0:
            begin
                for (int i = 0; i < 8; i++)
                begin
                    read_word[4*i +: 4] = ctrl.padcfg[i];
                end
            end
            REG_PADCFG_1:
            begin
                for (int i = 0; i < 8; i++)
                begin
                    read_word[4*i +: 4] = ctrl.padcfg[8 + i];
                end
            end
            REG_PADCFG_2:
            begin
                for (int i = 0; i < 8; i++)
                begin
                    read_word[4*i +: 4] = ctrl.padcfg[16 + i];
                end
            end
            REG_PADCFG_3:
            begin
                for (int i = 0; i < 8; i++)
                begin
                    read_word[4*i +: 4] = ctrl.padcfg[24 + i];
                end
            end
            default:
                read_word = '0; // Unmapped and write-only
        endcase
    end

    assign PRDATA = read_access ? read_word : '0;

endmodule

// ==== source/gpio_ctrl_regs.sv ====
module gpio_ctrl_regs (
    input  logic                 HCLK,
    input  logic                 HRESETn,
    input  gpio_pkg::reg_write_t wr,
    output gpio_pkg::pad_ctrl_t  ctrl
);

    import gpio_pkg::*;

    reg_index_t cfg_group;

    // Which group of eight pads a PADCFG write targets
    assign cfg_group = wr.index - REG_PADCFG_0;

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            ctrl.dir     <= '0; // All pads are inputs
            ctrl.en      <= '0;
            ctrl.out     <= '0;
            ctrl.inten   <= '0;
            ctrl.inttype <= {PAD_COUNT{INT_FALL}};
            ctrl.padcfg  <= '0;
        end
        else if (wr.valid)
        begin
            case (wr.index)
                REG_PADDIR:
                    ctrl.dir <= wr.data;
                REG_GPIOEN:
                    ctrl.en <= wr.data;
                REG_PADOUT:
                    ctrl.out <= wr.data;
                REG_PADOUTSET:
                    ctrl.out <= ctrl.out | wr.data;
                REG_PADOUTCLR:
                    ctrl.out <= ctrl.out & ~wr.data; // Ones clear
                REG_INTEN:
                    ctrl.inten <= wr.data;
                REG_INTTYPE_LO:
                begin
                    for (int i = 0; i < 16; i++)
                    begin
                        ctrl.inttype[i] <= wr.data[2*i +: 2];
                    end
                end
                REG_INTTYPE_HI:
                begin
                    for (int i = 0; i < 16; i++)
                    begin
                        ctrl.inttype[16 + i] <= wr.data[2*i +: 2];
                    end
                end
                REG_PADCFG_0, REG_PADCFG_1, REG_PADCFG_2, REG_PADCFG_3:
                begin
                    for (int i = 0; i < 8; i++)
                    begin
                        ctrl.padcfg[8*cfg_group + i] <= wr.data[4*i +: 4];
                    end
                end
                default:
                begin
                    // PADIN, INTSTATUS and unmapped words ignore writes
                end
            endcase
        end
    end

endmodule

// ==== source/gpio_input_sync.sv ====
module gpio_input_sync (
    input  logic                  HCLK,
    input  logic                  HRESETn,
    input  gpio_pkg::pad_vec_t    gpio_in,
    output gpio_pkg::pad_vec_t    pad_sync,
    output gpio_pkg::pad_vec_t    pad_in,
    output gpio_pkg::pad_events_t events
);

    import gpio_pkg::*;

    pad_vec_t sync_0;

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            sync_0   <= '0;
            pad_sync <= '0;
            pad_in   <= '0;
        end
        else
        begin
            sync_0   <= gpio_in;  // First metastability stage
            pad_sync <= sync_0;
            pad_in   <= pad_sync; // History for edge compare
        end
    end

    // Edges from the newest synced value against the previous one
    assign events = '{
        rise: pad_sync & ~pad_in,
        fall: ~pad_sync & pad_in
    };

endmodule

// ==== source/gpio_irq.sv ====
module gpio_irq (
    input  logic                  HCLK,
    input  logic                  HRESETn,
    input  gpio_pkg::pad_events_t events,
    input  gpio_pkg::pad_ctrl_t   ctrl,
    input  logic                  status_read,
    output gpio_pkg::pad_vec_t    status,
    output logic                  interrupt
);

    import gpio_pkg::*;

    pad_vec_t type_match;
    pad_vec_t hit;

    always_comb
    begin
        for (int i = 0; i < PAD_COUNT; i++)
        begin
            case (ctrl.inttype[i])
                INT_FALL:
                    type_match[i] = events.fall[i];
                INT_RISE:
                    type_match[i] = events.rise[i];
                INT_BOTH:
                    type_match[i] = events.rise[i] | events.fall[i];
                INT_NONE:
                    type_match[i] = 1'b0;
            endcase
        end
    end

    assign hit       = type_match & ctrl.inten & ctrl.en;
    assign interrupt = |hit; // One-cycle pulse per event

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            status <= '0;
        end
        else if (|hit)
        begin
            status <= status | hit; // New hits win over a read
        end
        else if (status_read)
        begin
            status <= '0;
        end
    end

endmodule

// ==== source/gpio_pkg.sv ====
package gpio_pkg;

    localparam int PAD_COUNT      = 32;
    localparam int APB_ADDR_WIDTH = 12;

    typedef logic [PAD_COUNT-1:0]      pad_vec_t;   // One bit per pad
    typedef logic [31:0]               bus_word_t;
    typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
    typedef logic [4:0]                reg_index_t; // Word index, PADDR[6:2]
    typedef logic [3:0]                pad_cfg_t;
    typedef logic [1:0]                int_mode_t;

    // Interrupt type codes
    localparam int_mode_t INT_FALL = 2'd0;
    localparam int_mode_t INT_RISE = 2'd1;
    localparam int_mode_t INT_BOTH = 2'd2;
    localparam int_mode_t INT_NONE = 2'd3;

    localparam reg_index_t REG_PADDIR     = 5'd0;  // 0x00
    localparam reg_index_t REG_GPIOEN     = 5'd1;  // 0x04
    localparam reg_index_t REG_PADIN      = 5'd2;  // 0x08
    localparam reg_index_t REG_PADOUT     = 5'd3;  // 0x0C
    localparam reg_index_t REG_PADOUTSET  = 5'd4;  // 0x10
    localparam reg_index_t REG_PADOUTCLR  = 5'd5;  // 0x14
    localparam reg_index_t REG_INTEN      = 5'd6;  // 0x18
    localparam reg_index_t REG_INTTYPE_LO = 5'd7;  // 0x1C, pads 0-15
    localparam reg_index_t REG_INTTYPE_HI = 5'd8;  // 0x20, pads 16-31
    localparam reg_index_t REG_INTSTATUS  = 5'd9;  // 0x24
    localparam reg_index_t REG_PADCFG_0   = 5'd10; // 0x28, pads 0-7
    localparam reg_index_t REG_PADCFG_1   = 5'd11; // 0x2C
    localparam reg_index_t REG_PADCFG_2   = 5'd12; // 0x30
    localparam reg_index_t REG_PADCFG_3   = 5'd13; // 0x34

    // Decoded bus write
    typedef struct packed {
        logic       valid;
        reg_index_t index;
        bus_word_t  data;
    } reg_write_t;

    // Per-pad control state
    typedef struct packed {
        pad_vec_t                     dir;
        pad_vec_t                     en;
        pad_vec_t                     out;
        pad_vec_t                     inten;
        int_mode_t [PAD_COUNT-1:0]    inttype;
        pad_cfg_t  [PAD_COUNT-1:0]    padcfg;
    } pad_ctrl_t;

    // Edge events, one cycle wide
    typedef struct packed {
        pad_vec_t rise;
        pad_vec_t fall;
    } pad_events_t;

endpackage
